// File: debug_port.f
+incdir+logic
+incdir+tb
logic/debug_pkg.sv
logic/debug_break_regs.sv
logic/debug_target.sv
logic/debug_sequencer.sv
logic/debug_subsystem.sv
tb/tb_debug_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f debug_port.f \
	--top-module tb_debug_subsystem \
	-Mdir obj_dir \
	-o tb_debug_subsystem
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_debug_subsystem
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// File: tb/debug_host_tasks.svh
`ifndef DEBUG_HOST_TASKS_SVH
`define DEBUG_HOST_TASKS_SVH

// Present one request and hold it until the sequencer takes it
task automatic send_request(input host_cmd_e cmd, input logic [7:0] target,
		input logic [31:0] data);
	@(negedge iCLOCK);
	host_req.cmd = cmd;
	host_req.target = target;
	host_req.data = data;
	host_req_valid = 1'b1;
	while (!host_req_ready) begin
		@(negedge iCLOCK);
	end
	// Transfer happens on the rising edge in between
	@(negedge iCLOCK);
	host_req_valid = 1'b0;
	host_rsp_ready = 1'b0;
endtask

// Hold ready low for hold_cycles valid cycles, then randomly
task automatic collect_response(input int hold_cycles, output host_rsp_t rsp);
	int held;
	bit taken;
	held = 0;
	taken = 1'b0;
	while (!taken) begin
		@(negedge iCLOCK);
		if (held < hold_cycles) begin
			host_rsp_ready = 1'b0;
		end else begin
			host_rsp_ready = ($urandom_range(3) != 0);
		end
		if (host_rsp_valid) begin
			if (host_rsp_ready) begin
				rsp = host_rsp;
				taken = 1'b1;
			end else begin
				held++;
			end
		end
	end
	@(negedge iCLOCK);
	host_rsp_ready = 1'b0;
endtask

`endif

// File: tb/tb_debug_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_defines.svh"

module tb_debug_subsystem import debug_pkg::*; ();

	localparam int SCENARIOS = 6;
	localparam int WATCHDOG_CYCLES = SCENARIOS * `DBG_RUN_LIMIT * 50;

	logic iCLOCK;
	logic inRESET;
	host_req_t host_req;
	logic host_req_valid;
	logic host_req_ready;
	host_rsp_t host_rsp;
	logic host_rsp_valid;
	logic host_rsp_ready;
	logic running;

	// Reference model of the debug target
	logic [31:0] model_gr [`DBG_GR_COUNT];
	logic [31:0] model_pc;
	logic [31:0] model_bp_addr;
	bit model_bp_en;
	bit model_active;
	bit running_seen;

	debug_subsystem UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.host_req(host_req),
		.host_req_valid(host_req_valid),
		.host_req_ready(host_req_ready),
		.host_rsp(host_rsp),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp_ready(host_rsp_ready),
		.running(running)
	);

	always #4 iCLOCK = ~iCLOCK;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	`include "debug_host_tasks.svh"

	// Expected response from the command rules and the model update
	task automatic predict_response(input host_cmd_e cmd, input logic [7:0] target,
			input logic [31:0] data, output host_rsp_t exp);
		int k;
		bit hit;
		bit is_gr;
		bit is_pc;
		exp = '0;
		hit = 1'b0;
		is_gr = (32'(target) < `DBG_GR_COUNT);
		is_pc = (target == `DBG_TARGET_PC);
		if (!model_active) begin
			exp.error = (cmd != HOST_AC);
			model_active = (cmd == HOST_AC);
		end else begin
			case (cmd)
				HOST_AC, HOST_NP: exp.error = 1'b0;
				HOST_ID: model_active = 1'b0;
				HOST_RR, HOST_RW: begin
					if (!is_gr && !is_pc) begin
						exp.error = 1'b1;
						model_active = 1'b0;
					end else if (cmd == HOST_RR) begin
						exp.data = is_pc ? model_pc : model_gr[target[4:0]];
					end else if (is_pc) begin
						model_pc = data;
					end else begin
						model_gr[target[4:0]] = data;
					end
				end
				HOST_SE: begin
					model_pc = model_pc + `DBG_PC_STEP;
					exp.data = model_pc;
				end
				HOST_SB: begin
					model_bp_addr = data;
					model_bp_en = 1'b1;
				end
				HOST_BE: begin
					for (k = 0; k <= `DBG_RUN_LIMIT; k++) begin
						if (model_bp_en && (model_pc + 32'(k) * `DBG_PC_STEP) == model_bp_addr) begin
							hit = 1'b1;
						end
					end
					if (hit) begin
						model_pc = model_bp_addr;
					end else begin
						// Run limit reached and the error drops the debugger to idle
						model_pc = model_pc + `DBG_RUN_LIMIT * `DBG_PC_STEP;
						exp.error = 1'b1;
						model_active = 1'b0;
					end
					exp.data = model_pc;
				end
				default: exp.error = 1'b1;
			endcase
		end
	endtask

	task automatic run_cmd(input host_cmd_e cmd, input logic [7:0] target,
			input logic [31:0] data, input int hold_cycles);
		host_rsp_t expected;
		host_rsp_t got;
		predict_response(cmd, target, data, expected);
		send_request(cmd, target, data);
		collect_response(hold_cycles, got);
		assert (got.error == expected.error)
		else report_mismatch("host_rsp.error", 32'(got.error), 32'(expected.error));
		assert (got.data == expected.data)
		else report_mismatch("host_rsp.data", got.data, expected.data);
	endtask

	// Response must stay put while the host stalls it
	rsp_stable_while_stalled: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(host_rsp_valid && !host_rsp_ready) |=> (host_rsp_valid && $stable(host_rsp)))
	else abort_run("Host response changed or dropped while host_rsp_ready was low");

	always @(posedge iCLOCK) begin
		if (running) begin
			running_seen <= 1'b1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge iCLOCK);
		abort_run($sformatf("Watchdog expired after %0d clock cycles", WATCHDOG_CYCLES));
	end

	initial begin
		int i;
		logic [31:0] bp;
		void'($urandom(78));
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		host_req = '{cmd: HOST_NP, target: 8'h00, data: 32'h0};
		host_req_valid = 1'b0;
		host_rsp_ready = 1'b0;
		for (i = 0; i < `DBG_GR_COUNT; i++) begin
			model_gr[i] = '0;
		end
		model_pc = '0;
		model_bp_addr = '0;
		model_bp_en = 1'b0;
		model_active = 1'b0;
		running_seen = 1'b0;
		repeat (3) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		assert (host_req_ready && !host_rsp_valid && !running)
		else abort_run("Handshake outputs not in their reset state after reset");

		// Rejection before AC and after ID
		run_cmd(HOST_NP, 8'h00, 32'h0, 0);
		run_cmd(HOST_RR, 8'h00, 32'h0, 0);
		run_cmd(HOST_RW, 8'h01, 32'hDEAD_BEEF, 0);
		run_cmd(HOST_SE, 8'h00, 32'h0, 0);
		run_cmd(HOST_BE, 8'h00, 32'h0, 0);
		run_cmd(HOST_SB, 8'h00, 32'h10, 0);
		run_cmd(HOST_ID, 8'h00, 32'h0, 0);
		run_cmd(HOST_AC, 8'h00, 32'h0, 0);
		run_cmd(HOST_NP, 8'h00, 32'h0, 0);
		run_cmd(host_cmd_e'(8'h5A), 8'h00, 32'h0, 0);
		run_cmd(HOST_ID, 8'h00, 32'h0, 0);
		run_cmd(HOST_RR, 8'h00, 32'h0, 0);

		// Random register writes and a full read back
		run_cmd(HOST_AC, 8'h00, 32'h0, 0);
		repeat (12) begin
			run_cmd(HOST_RW, 8'($urandom_range(`DBG_GR_COUNT - 1)), $urandom, 0);
		end
		run_cmd(HOST_RW, `DBG_TARGET_PC, $urandom, 0);
		for (i = 0; i < `DBG_GR_COUNT; i++) begin
			run_cmd(HOST_RR, 8'(i), 32'h0, 0);
		end
		run_cmd(HOST_RR, `DBG_TARGET_PC, 32'h0, 0);

		// Unknown target deactivates
		run_cmd(HOST_RR, 8'd40, 32'h0, 0);
		run_cmd(HOST_RR, 8'd0, 32'h0, 0);
		run_cmd(HOST_AC, 8'h00, 32'h0, 0);

		// Single step
		run_cmd(HOST_SE, 8'h00, 32'h0, 0);
		run_cmd(HOST_RR, `DBG_TARGET_PC, 32'h0, 0);

		// Run to a reachable breakpoint
		run_cmd(HOST_RW, `DBG_TARGET_PC, 32'h100, 0);
		bp = 32'h100 + 32'($urandom_range(`DBG_RUN_LIMIT - 1, 1)) * `DBG_PC_STEP;
		run_cmd(HOST_SB, 8'h00, bp, 0);
		running_seen = 1'b0;
		run_cmd(HOST_BE, 8'h00, 32'h0, 0);
		assert (running_seen) else abort_run("running never went high during BE");
		run_cmd(HOST_RR, `DBG_TARGET_PC, 32'h0, 0);

		// Breakpoint behind the PC so the run limit ends a stalled run
		run_cmd(HOST_SB, 8'h00, bp - `DBG_PC_STEP, 0);
		run_cmd(HOST_BE, 8'h00, 32'h0, 6);
		run_cmd(HOST_RR, `DBG_TARGET_PC, 32'h0, 0);
		run_cmd(HOST_AC, 8'h00, 32'h0, 0);
		run_cmd(HOST_RR, `DBG_TARGET_PC, 32'h0, 0);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/debug_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module debug_subsystem import debug_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire host_req_t host_req,
	input wire host_req_valid,
	output wire host_req_ready,
	output wire host_rsp_t host_rsp,
	output wire host_rsp_valid,
	input wire host_rsp_ready,
	output wire running
);

	// Core link
	wire core_req_t core_req;
	wire core_req_valid;
	wire core_req_ready;
	wire core_rsp_t core_rsp;
	wire core_rsp_valid;

	// Breakpoint link
	wire bp_write;
	wire [31:0] bp_addr;
	wire [31:0] pc;
	wire bp_hit;
	wire limit_hit;

	debug_sequencer u_sequencer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.host_req(host_req),
		.host_req_valid(host_req_valid),
		.host_req_ready(host_req_ready),
		.host_rsp(host_rsp),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp_ready(host_rsp_ready),
		.core_req(core_req),
		.core_req_valid(core_req_valid),
		.core_req_ready(core_req_ready),
		.core_rsp(core_rsp),
		.core_rsp_valid(core_rsp_valid)
	);

	debug_target u_target (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.core_req(core_req),
		.core_req_valid(core_req_valid),
		.core_req_ready(core_req_ready),
		.core_rsp(core_rsp),
		.core_rsp_valid(core_rsp_valid),
		.bp_write(bp_write),
		.bp_addr(bp_addr),
		.pc(pc),
		.running(running),
		.bp_hit(bp_hit),
		.limit_hit(limit_hit)
	);

	debug_break_regs u_break_regs (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.bp_write(bp_write),
		.bp_addr(bp_addr),
		.pc(pc),
		.running(running),
		.bp_hit(bp_hit),
		.limit_hit(limit_hit)
	);

endmodule

`default_nettype wire

// File: logic/debug_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module debug_sequencer import debug_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire host_req_t host_req,
	input wire host_req_valid,
	output logic host_req_ready,
	output host_rsp_t host_rsp,
	output logic host_rsp_valid,
	input wire host_rsp_ready,
	output core_req_t core_req,
	output logic core_req_valid,
	input wire core_req_ready,
	input wire core_rsp_t core_rsp,
	input wire core_rsp_valid
);

	seq_state_e state;
	// State to return to once the response is taken
	seq_state_e after_rsp;

	logic accept;
	logic is_core_cmd;
	core_cmd_e core_cmd;
	logic local_error;
	logic core_done;

	assign host_req_ready = (state == IDLE) || (state == ACTIVE);
	assign accept = host_req_valid && host_req_ready;
	assign host_rsp_valid = (state == RESPOND);
	assign core_req_valid = (state == ISSUE);
	assign core_done = (state == WAIT_CORE) && core_rsp_valid;

	// Host to core command mapping
	always_comb begin
		is_core_cmd = 1'b1;
		core_cmd = READ_REG;
		case (host_req.cmd)
			HOST_RR: core_cmd = READ_REG;
			HOST_RW: core_cmd = WRITE_REG;
			HOST_SE: core_cmd = STEP;
			HOST_BE: core_cmd = GO;
			HOST_SB: core_cmd = SET_BREAK;
			default: is_core_cmd = 1'b0;
		endcase
	end

	// Error bit for commands answered without the core
	always_comb begin
		if (state == IDLE) begin
			local_error = (host_req.cmd != HOST_AC);
		end else begin
			case (host_req.cmd)
				HOST_AC,
				HOST_ID,
				HOST_NP: local_error = 1'b0;
				default: local_error = 1'b1;
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			after_rsp <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						state <= RESPOND;
						after_rsp <= (host_req.cmd == HOST_AC) ? ACTIVE : IDLE;
					end
				end
				ACTIVE: begin
					if (accept) begin
						if (is_core_cmd) begin
							state <= ISSUE;
						end else begin
							state <= RESPOND;
							after_rsp <= (host_req.cmd == HOST_ID) ? IDLE : ACTIVE;
						end
					end
				end
				ISSUE: begin
					if (core_req_ready) begin
						state <= WAIT_CORE;
					end
				end
				WAIT_CORE: begin
					if (core_rsp_valid) begin
						state <= RESPOND;
						// A failing core command deactivates the debugger
						after_rsp <= core_rsp.error ? IDLE : ACTIVE;
					end
				end
				RESPOND: begin
					if (host_rsp_ready) begin
						state <= after_rsp;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Core request payload, held while ISSUE waits for ready
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			core_req.cmd <= core_cmd;
			core_req.target <= host_req.target;
			core_req.data <= host_req.data;
		end
	end

	// Response payload, held through host back-pressure
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			host_rsp.error <= local_error;
			host_rsp.data <= '0;
		end else if (core_done) begin
			host_rsp.error <= core_rsp.error;
			host_rsp.data <= core_rsp.data;
		end
	end

endmodule

`default_nettype wire

// File: logic/debug_target.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_defines.svh"

module debug_target import debug_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire core_req_t core_req,
	input wire core_req_valid,
	output logic core_req_ready,
	output core_rsp_t core_rsp,
	output logic core_rsp_valid,
	output logic bp_write,
	output logic [31:0] bp_addr,
	output logic [31:0] pc,
	output logic running,
	input wire bp_hit,
	input wire limit_hit
);

	localparam int GR_AW = $clog2(`DBG_GR_COUNT);

	logic [31:0] gr [`DBG_GR_COUNT];
	logic accept;
	logic is_gr;
	logic is_pc;
	logic [GR_AW-1:0] gr_idx;
	logic run_stop;
	logic rsp_fire;
	core_rsp_t rsp_next;

	// No new command while the program is running
	assign core_req_ready = !running;
	assign accept = core_req_valid && core_req_ready;
	assign is_gr = core_req.target < 8'(`DBG_GR_COUNT);
	assign is_pc = core_req.target == `DBG_TARGET_PC;
	assign gr_idx = core_req.target[GR_AW-1:0];
	assign run_stop = running && (bp_hit || limit_hit);

	assign bp_write = accept && (core_req.cmd == SET_BREAK);
	assign bp_addr = core_req.data;

	always_comb begin
		rsp_fire = 1'b0;
		rsp_next = '0;
		if (run_stop) begin
			rsp_fire = 1'b1;
			rsp_next.error = !bp_hit;
			rsp_next.data = pc;
		end else if (accept) begin
			rsp_fire = 1'b1;
			case (core_req.cmd)
				READ_REG: begin
					if (is_gr) begin
						rsp_next.data = gr[gr_idx];
					end else if (is_pc) begin
						rsp_next.data = pc;
					end else begin
						rsp_next.error = 1'b1;
					end
				end
				WRITE_REG: rsp_next.error = !(is_gr || is_pc);
				STEP: rsp_next.data = pc + `DBG_PC_STEP;
				// Answered when the run stops
				GO: rsp_fire = 1'b0;
				SET_BREAK: rsp_next.data = '0;
				default: rsp_next.error = 1'b1;
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `DBG_GR_COUNT; i++) begin
				gr[i] <= '0;
			end
			pc <= '0;
			running <= 1'b0;
			core_rsp_valid <= 1'b0;
		end else begin
			core_rsp_valid <= rsp_fire;
			if (running) begin
				if (run_stop) begin
					running <= 1'b0;
				end else begin
					pc <= pc + `DBG_PC_STEP;
				end
			end else if (accept) begin
				case (core_req.cmd)
					WRITE_REG: begin
						if (is_gr) begin
							gr[gr_idx] <= core_req.data;
						end else if (is_pc) begin
							pc <= core_req.data;
						end
					end
					STEP: pc <= pc + `DBG_PC_STEP;
					GO: running <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rsp_fire) begin
			core_rsp <= rsp_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/debug_break_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_defines.svh"

module debug_break_regs (
	input wire iCLOCK,
	input wire inRESET,
	input wire bp_write,
	input wire [31:0] bp_addr,
	input wire [31:0] pc,
	input wire running,
	output logic bp_hit,
	output logic limit_hit
);

	localparam int CNT_W = $clog2(`DBG_RUN_LIMIT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`DBG_RUN_LIMIT);

	logic [31:0] break_addr;
	logic break_en;
	logic [CNT_W-1:0] run_count;

	assign bp_hit = running && break_en && (break_addr == pc);
	assign limit_hit = running && (run_count == LIMIT);

	// Breakpoint address and enable
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			break_addr <= '0;
			break_en <= 1'b0;
		end else if (bp_write) begin
			break_addr <= bp_addr;
			break_en <= 1'b1;
		end
	end

	// Run cycle counter, one count per PC advance
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			run_count <= '0;
		end else if (!running) begin
			run_count <= '0;
		end else if (!limit_hit) begin
			run_count <= run_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/debug_pkg.sv
`default_nettype none

package debug_pkg;

	// Host command codes, ASCII
	typedef enum logic [7:0] {
		HOST_AC = 8'h41,
		HOST_ID = 8'h49,
		HOST_NP = 8'h4E,
		HOST_RR = 8'h52,
		HOST_RW = 8'h57,
		HOST_SE = 8'h53,
		HOST_BE = 8'h42,
		HOST_SB = 8'h50
	} host_cmd_e;

	// Core debug unit commands
	typedef enum logic [3:0] {
		READ_REG  = 4'h0,
		WRITE_REG = 4'h1,
		GO        = 4'h8,
		STEP      = 4'hA,
		SET_BREAK = 4'hB
	} core_cmd_e;

	typedef struct packed {
		host_cmd_e   cmd;
		logic [7:0]  target;
		logic [31:0] data;
	} host_req_t;

	typedef struct packed {
		logic        error;
		logic [31:0] data;
	} host_rsp_t;

	typedef struct packed {
		core_cmd_e   cmd;
		logic [7:0]  target;
		logic [31:0] data;
	} core_req_t;

	typedef struct packed {
		logic        error;
		logic [31:0] data;
	} core_rsp_t;

	// Sequencer FSM
	typedef enum logic [2:0] {
		IDLE,
		ACTIVE,
		ISSUE,
		WAIT_CORE,
		RESPOND
	} seq_state_e;

endpackage

`default_nettype wire

// File: logic/debug_defines.svh
`ifndef DEBUG_DEFINES_SVH
`define DEBUG_DEFINES_SVH

// General register file size
`define DBG_GR_COUNT 32

// Program counter advance per step or run cycle
`define DBG_PC_STEP 32'd4

// Run cycles allowed before giving up on a breakpoint
`define DBG_RUN_LIMIT 64

// Target code of the program counter
`define DBG_TARGET_PC 8'd67

`endif
